//--- rv_decode.f
hdl/decode_pkg.sv
hdl/inst_fields_if.sv
hdl/uop_if.sv
hdl/inst_capture.sv
hdl/uop_decoder.sv
hdl/uop_register.sv
hdl/rv_decode.sv
sim/rv_decode_assert.sv
sim/rv_decode_tb.sv

//--- Makefile
TOP = rv_decode_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f rv_decode.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f rv_decode.f

clean:
	rm -rf obj_dir

//--- sim/rv_decode_tb.sv
`timescale 1ns/1ps

module rv_decode_tb;
    import decode_pkg::*;

    typedef struct packed {
        logic                illegal;
        logic                rf_w_en;
        reg_addr_t           rf_w_addr;
        reg_addr_t           rf_r_addr_1;
        reg_addr_t           rf_r_addr_2;
        imm_type_e           imm_type;
        alu_arg_1_sel_e      alu_arg_1_sel;
        alu_arg_2_sel_e      alu_arg_2_sel;
        alu_op_e             alu_op;
        data_mem_op_e        data_mem_op;
        branch_type_e        branch_type;
        branch_pc_sel_e      branch_pc_sel;
        regfile_w_data_sel_e rf_w_data_sel;
        csr_addr_t           csr_addr;
        logic                csr_w_en;
        csr_write_type_e     csr_w_type;
    } uop_t;

    localparam opcode_t OPCODE_FENCE = 7'b0001111;
    localparam int      NUM_INSTS    = 2000;

    logic                i_clk   = 1'b0;
    logic                i_rst_n = 1'b0;
    logic                i_valid = 1'b0;
    inst_t               i_inst  = '0;
    logic                o_valid;
    logic                o_illegal;
    logic                o_rf_w_en;
    reg_addr_t           o_rf_w_addr;
    reg_addr_t           o_rf_r_addr_1;
    reg_addr_t           o_rf_r_addr_2;
    imm_type_e           o_imm_type;
    alu_arg_1_sel_e      o_alu_arg_1_sel;
    alu_arg_2_sel_e      o_alu_arg_2_sel;
    alu_op_e             o_alu_op;
    data_mem_op_e        o_data_mem_op;
    branch_type_e        o_branch_type;
    branch_pc_sel_e      o_branch_pc_sel;
    regfile_w_data_sel_e o_rf_w_data_sel;
    csr_addr_t           o_csr_addr;
    logic                o_csr_w_en;
    csr_write_type_e     o_csr_w_type;

    // fence must decode as illegal
    opcode_t opcode_pool [0:10] = '{
        OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH, OPCODE_LOAD,
        OPCODE_STORE, OPCODE_ARITH_IMM, OPCODE_ARITH, OPCODE_SYSTEM, OPCODE_FENCE
    };

    uop_t        exp_q [$];
    int unsigned due_q [$];
    int unsigned cyc         = 0;
    int unsigned wait_cycles = 0;
    int unsigned issued      = 0;
    int unsigned drain       = 0;

    rv_decode i_rv_decode (.*);

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_flag(string name, logic got, logic want);
        if (got !== want) begin
            stop_with_failure($sformatf("** Error: %s is %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_reg_addr(string name, reg_addr_t got, reg_addr_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("** Error: %s is %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_csr_addr(string name, csr_addr_t got, csr_addr_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("** Error: %s is %h, expected %h", name, got, want));
        end
    endtask

    // enum fields, widened to the widest control enum
    task automatic check_ctrl(string name, logic [3:0] got, logic [3:0] want);
        if (got !== want) begin
            stop_with_failure($sformatf("** Error: %s is %h, expected %h", name, got, want));
        end
    endtask

    function automatic uop_t expected_uop(inst_t w);
        uop_t    u;
        opcode_t op;
        funct3_t f3;
        logic    alt;
        logic    f7_legal;
        op            = w[6:0];
        f3            = w[14:12];
        alt           = (w[31:25] == FUNCT7_ALT);
        f7_legal      = alt || (w[31:25] == FUNCT7_BASE);
        u             = '0;
        u.rf_w_addr   = w[11:7];
        u.rf_r_addr_1 = w[19:15];
        u.rf_r_addr_2 = w[24:20];
        u.csr_addr    = w[31:20];
        case (op)
            OPCODE_LUI: begin
                u.rf_w_en       = 1'b1;
                u.imm_type      = IMM_TYPE_U;
                u.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                u.alu_op        = ALU_OP_ARG_2_BYPASS;
            end
            OPCODE_AUIPC: begin
                u.rf_w_en       = 1'b1;
                u.imm_type      = IMM_TYPE_U;
                u.alu_arg_1_sel = ALU_ARG_1_SEL_PC;
                u.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                u.rf_w_en       = 1'b1;
                u.alu_arg_1_sel = ALU_ARG_1_SEL_PC;
                u.alu_arg_2_sel = ALU_ARG_2_SEL_4;
                u.branch_type   = BRANCH_TYPE_UNCONDITIONAL;
                u.imm_type      = (op == OPCODE_JAL) ? IMM_TYPE_J : IMM_TYPE_I;
                if (op == OPCODE_JALR) begin
                    u.branch_pc_sel = BRANCH_PC_SEL_REGFILE_R_DATA_1_PLUS_IMM;
                end
            end
            OPCODE_BRANCH: begin
                u.imm_type    = IMM_TYPE_B;
                u.branch_type = BRANCH_TYPE_CONDITIONAL;
                case (f3)
                    FUNCT3_BEQ:  u.alu_op = ALU_OP_SEQ;
                    FUNCT3_BNE:  u.alu_op = ALU_OP_SNEQ;
                    FUNCT3_BLT:  u.alu_op = ALU_OP_SLT;
                    FUNCT3_BGE:  u.alu_op = ALU_OP_SGE;
                    FUNCT3_BLTU: u.alu_op = ALU_OP_SLTU;
                    FUNCT3_BGEU: u.alu_op = ALU_OP_SGEU;
                    default:     u.illegal = 1'b1;
                endcase
            end
            OPCODE_LOAD: begin
                u.rf_w_en       = 1'b1;
                u.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                u.rf_w_data_sel = REGFILE_W_DATA_SEL_DATA_MEM;
                case (f3)
                    FUNCT3_LB:  u.data_mem_op = DATA_MEM_OP_LOAD_BYTE;
                    FUNCT3_LH:  u.data_mem_op = DATA_MEM_OP_LOAD_HALF;
                    FUNCT3_LW:  u.data_mem_op = DATA_MEM_OP_LOAD_WORD;
                    FUNCT3_LBU: u.data_mem_op = DATA_MEM_OP_LOAD_BYTE_UNSIGNED;
                    FUNCT3_LHU: u.data_mem_op = DATA_MEM_OP_LOAD_HALF_UNSIGNED;
                    default:    u.illegal = 1'b1;
                endcase
            end
            OPCODE_STORE: begin
                u.imm_type      = IMM_TYPE_S;
                u.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                case (f3)
                    FUNCT3_SB: u.data_mem_op = DATA_MEM_OP_STORE_BYTE;
                    FUNCT3_SH: u.data_mem_op = DATA_MEM_OP_STORE_HALF;
                    FUNCT3_SW: u.data_mem_op = DATA_MEM_OP_STORE_WORD;
                    default:   u.illegal = 1'b1;
                endcase
            end
            OPCODE_ARITH_IMM, OPCODE_ARITH: begin
                u.rf_w_en = 1'b1;
                if (op == OPCODE_ARITH_IMM) begin
                    u.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                end
                case (f3)
                    // addi has no funct7 field
                    FUNCT3_ADD_SUB: begin
                        if (op == OPCODE_ARITH) begin
                            u.alu_op  = alt ? ALU_OP_SUB : ALU_OP_ADD;
                            u.illegal = !f7_legal;
                        end
                    end
                    FUNCT3_SLL: begin
                        u.alu_op  = ALU_OP_SLL;
                        u.illegal = !f7_legal;
                    end
                    FUNCT3_SLT:  u.alu_op = ALU_OP_SLT;
                    FUNCT3_SLTU: u.alu_op = ALU_OP_SLTU;
                    FUNCT3_XOR:  u.alu_op = ALU_OP_XOR;
                    FUNCT3_SRL_SRA: begin
                        u.alu_op  = alt ? ALU_OP_SRA : ALU_OP_SRL;
                        u.illegal = !f7_legal;
                    end
                    FUNCT3_OR:   u.alu_op = ALU_OP_OR;
                    FUNCT3_AND:  u.alu_op = ALU_OP_AND;
                endcase
            end
            OPCODE_SYSTEM: begin
                u.rf_w_en       = 1'b1;
                u.csr_w_en      = 1'b1;
                u.rf_w_data_sel = REGFILE_W_DATA_SEL_CSR;
                // low bits give the write kind, bit 2 the zimm form
                case (f3[1:0])
                    2'd1:    u.csr_w_type = CSR_WRITE_TYPE_COPY;
                    2'd2:    u.csr_w_type = CSR_WRITE_TYPE_SET;
                    2'd3:    u.csr_w_type = CSR_WRITE_TYPE_CLEAR;
                    default: u.illegal = 1'b1;
                endcase
                if (f3[2]) begin
                    u.imm_type      = IMM_TYPE_CSR;
                    u.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                    u.alu_op        = ALU_OP_ARG_2_BYPASS;
                end else begin
                    u.alu_op = ALU_OP_ARG_1_BYPASS;
                end
            end
            default: u.illegal = 1'b1;
        endcase
        if (u.illegal) begin
            u.rf_w_en     = 1'b0;
            u.csr_w_en    = 1'b0;
            u.data_mem_op = DATA_MEM_OP_NONE;
            u.branch_type = BRANCH_TYPE_NONE;
        end
        return u;
    endfunction

    task automatic check_outputs();
        uop_t        want;
        int unsigned due;
        if (o_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("o_valid was raised with no instruction in flight");
            end else begin
                want        = exp_q.pop_front();
                due         = due_q.pop_front();
                wait_cycles = 0;
                if (cyc != due) begin
                    stop_with_failure($sformatf(
                        "instruction came out in cycle %0d instead of cycle %0d", cyc, due));
                end else begin
                    check_flag("o_illegal", o_illegal, want.illegal);
                    check_flag("o_rf_w_en", o_rf_w_en, want.rf_w_en);
                    check_flag("o_csr_w_en", o_csr_w_en, want.csr_w_en);
                    check_reg_addr("o_rf_w_addr", o_rf_w_addr, want.rf_w_addr);
                    check_reg_addr("o_rf_r_addr_1", o_rf_r_addr_1, want.rf_r_addr_1);
                    check_reg_addr("o_rf_r_addr_2", o_rf_r_addr_2, want.rf_r_addr_2);
                    check_csr_addr("o_csr_addr", o_csr_addr, want.csr_addr);
                    check_ctrl("o_imm_type", 4'(o_imm_type), 4'(want.imm_type));
                    check_ctrl("o_alu_arg_1_sel", 4'(o_alu_arg_1_sel), 4'(want.alu_arg_1_sel));
                    check_ctrl("o_alu_arg_2_sel", 4'(o_alu_arg_2_sel), 4'(want.alu_arg_2_sel));
                    check_ctrl("o_alu_op", 4'(o_alu_op), 4'(want.alu_op));
                    check_ctrl("o_data_mem_op", 4'(o_data_mem_op), 4'(want.data_mem_op));
                    check_ctrl("o_branch_type", 4'(o_branch_type), 4'(want.branch_type));
                    check_ctrl("o_branch_pc_sel", 4'(o_branch_pc_sel), 4'(want.branch_pc_sel));
                    check_ctrl("o_rf_w_data_sel", 4'(o_rf_w_data_sel), 4'(want.rf_w_data_sel));
                    check_ctrl("o_csr_w_type", 4'(o_csr_w_type), 4'(want.csr_w_type));
                end
            end
        end else if (exp_q.size() != 0) begin
            wait_cycles++;
            if (wait_cycles > 10) begin
                stop_with_failure("o_valid did not arrive within 10 cycles");
            end
        end
    endtask

    task automatic drive_next();
        logic [31:0] r;
        inst_t       w;
        r = $urandom();
        w = $urandom();
        // one in eight words stays fully random
        if (r[10:8] != 3'd0) begin
            w[6:0] = opcode_pool[r[15:12] % 4'd11];
            case (r[17:16])
                2'd0:    w[31:25] = FUNCT7_BASE;
                2'd1:    w[31:25] = FUNCT7_ALT;
                default: w[31:25] = w[31:25];
            endcase
            // mret or wfi
            if (r[24:21] == 4'd0) begin
                w = r[25] ? 32'h3020_0073 : 32'h1050_0073;
            end
        end
        i_valid = (r[6:0] < 7'd90);
        i_inst  = w;
        if (i_valid) begin
            exp_q.push_back(expected_uop(w));
            due_q.push_back(cyc + 2);
            issued++;
        end
    endtask

    initial begin
        void'($urandom(32'h786d_2366));
        repeat (3) @(negedge i_clk);
        i_rst_n = 1'b1;
        check_flag("o_valid", o_valid, 1'b0);
        check_flag("o_rf_w_en", o_rf_w_en, 1'b0);
        check_flag("o_csr_w_en", o_csr_w_en, 1'b0);
        check_ctrl("o_data_mem_op", 4'(o_data_mem_op), 4'(DATA_MEM_OP_NONE));
        check_ctrl("o_branch_type", 4'(o_branch_type), 4'(BRANCH_TYPE_NONE));
        while (issued < NUM_INSTS) begin
            @(negedge i_clk);
            check_outputs();
            drive_next();
        end
        while (exp_q.size() != 0 && drain < 10) begin
            @(negedge i_clk);
            check_outputs();
            i_valid = 1'b0;
            drain++;
        end
        if (exp_q.size() != 0) begin
            stop_with_failure("instructions still in flight 10 cycles after the last one");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end
endmodule

//--- sim/rv_decode_assert.sv
`timescale 1ns/1ps

module rv_decode_assert (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_valid,
    input logic                     i_out_valid,
    input logic                     i_illegal,
    input logic                     i_rf_w_en,
    input logic                     i_csr_w_en,
    input decode_pkg::data_mem_op_e i_data_mem_op,
    input decode_pkg::branch_type_e i_branch_type
);
    import decode_pkg::*;

    squash_on_illegal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_illegal |-> !i_rf_w_en && !i_csr_w_en && i_data_mem_op == DATA_MEM_OP_NONE
            && i_branch_type == BRANCH_TYPE_NONE)
        else $error("side effect left active on an illegal instruction");

    // output strobe is the input strobe two edges late
    two_cycle_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid == $past(i_valid, 2))
        else $error("o_valid does not follow i_valid by two cycles");

    valid_low_after_reset: assert property (@(posedge i_clk)
        !i_rst_n |=> !i_out_valid)
        else $error("o_valid high in the cycle after reset");
endmodule

bind rv_decode rv_decode_assert i_rv_decode_assert (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_valid),
    .i_out_valid   (o_valid),
    .i_illegal     (o_illegal),
    .i_rf_w_en     (o_rf_w_en),
    .i_csr_w_en    (o_csr_w_en),
    .i_data_mem_op (o_data_mem_op),
    .i_branch_type (o_branch_type)
);

//--- hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_valid,
    input  decode_pkg::inst_t               i_inst,
    output logic                            o_valid,
    output logic                            o_illegal,
    output logic                            o_rf_w_en,
    output decode_pkg::reg_addr_t           o_rf_w_addr,
    output decode_pkg::reg_addr_t           o_rf_r_addr_1,
    output decode_pkg::reg_addr_t           o_rf_r_addr_2,
    output decode_pkg::imm_type_e           o_imm_type,
    output decode_pkg::alu_arg_1_sel_e      o_alu_arg_1_sel,
    output decode_pkg::alu_arg_2_sel_e      o_alu_arg_2_sel,
    output decode_pkg::alu_op_e             o_alu_op,
    output decode_pkg::data_mem_op_e        o_data_mem_op,
    output decode_pkg::branch_type_e        o_branch_type,
    output decode_pkg::branch_pc_sel_e      o_branch_pc_sel,
    output decode_pkg::regfile_w_data_sel_e o_rf_w_data_sel,
    output decode_pkg::csr_addr_t           o_csr_addr,
    output logic                            o_csr_w_en,
    output decode_pkg::csr_write_type_e     o_csr_w_type
);

    inst_fields_if inst_fields ();
    uop_if         uop ();

    // stage 1
    inst_capture i_inst_capture (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_inst   (i_inst),
        .o_fields (inst_fields)
    );

    uop_decoder i_uop_decoder (
        .i_fields (inst_fields),
        .o_uop    (uop)
    );

    // stage 2
    uop_register i_uop_register (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_uop           (uop),
        .o_valid         (o_valid),
        .o_illegal       (o_illegal),
        .o_rf_w_en       (o_rf_w_en),
        .o_rf_w_addr     (o_rf_w_addr),
        .o_rf_r_addr_1   (o_rf_r_addr_1),
        .o_rf_r_addr_2   (o_rf_r_addr_2),
        .o_imm_type      (o_imm_type),
        .o_alu_arg_1_sel (o_alu_arg_1_sel),
        .o_alu_arg_2_sel (o_alu_arg_2_sel),
        .o_alu_op        (o_alu_op),
        .o_data_mem_op   (o_data_mem_op),
        .o_branch_type   (o_branch_type),
        .o_branch_pc_sel (o_branch_pc_sel),
        .o_rf_w_data_sel (o_rf_w_data_sel),
        .o_csr_addr      (o_csr_addr),
        .o_csr_w_en      (o_csr_w_en),
        .o_csr_w_type    (o_csr_w_type)
    );
endmodule

//--- hdl/uop_register.sv
`timescale 1ns/1ps

module uop_register (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    uop_if.consumer                         i_uop,
    output logic                            o_valid,
    output logic                            o_illegal,
    output logic                            o_rf_w_en,
    output decode_pkg::reg_addr_t           o_rf_w_addr,
    output decode_pkg::reg_addr_t           o_rf_r_addr_1,
    output decode_pkg::reg_addr_t           o_rf_r_addr_2,
    output decode_pkg::imm_type_e           o_imm_type,
    output decode_pkg::alu_arg_1_sel_e      o_alu_arg_1_sel,
    output decode_pkg::alu_arg_2_sel_e      o_alu_arg_2_sel,
    output decode_pkg::alu_op_e             o_alu_op,
    output decode_pkg::data_mem_op_e        o_data_mem_op,
    output decode_pkg::branch_type_e        o_branch_type,
    output decode_pkg::branch_pc_sel_e      o_branch_pc_sel,
    output decode_pkg::regfile_w_data_sel_e o_rf_w_data_sel,
    output decode_pkg::csr_addr_t           o_csr_addr,
    output logic                            o_csr_w_en,
    output decode_pkg::csr_write_type_e     o_csr_w_type
);
    import decode_pkg::*;

    // side effects are squashed here on illegal
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid       <= 1'b0;
            o_illegal     <= 1'b0;
            o_rf_w_en     <= 1'b0;
            o_csr_w_en    <= 1'b0;
            o_data_mem_op <= DATA_MEM_OP_NONE;
            o_branch_type <= BRANCH_TYPE_NONE;
        end else begin
            o_valid <= i_uop.valid;
            if (i_uop.valid) begin
                o_illegal     <= i_uop.illegal;
                o_rf_w_en     <= i_uop.rf_w_en && !i_uop.illegal;
                o_csr_w_en    <= i_uop.csr_w_en && !i_uop.illegal;
                o_data_mem_op <= i_uop.illegal ? DATA_MEM_OP_NONE : i_uop.data_mem_op;
                o_branch_type <= i_uop.illegal ? BRANCH_TYPE_NONE : i_uop.branch_type;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_uop.valid) begin
            o_rf_w_addr     <= i_uop.rf_w_addr;
            o_rf_r_addr_1   <= i_uop.rf_r_addr_1;
            o_rf_r_addr_2   <= i_uop.rf_r_addr_2;
            o_imm_type      <= i_uop.imm_type;
            o_alu_arg_1_sel <= i_uop.alu_arg_1_sel;
            o_alu_arg_2_sel <= i_uop.alu_arg_2_sel;
            o_alu_op        <= i_uop.alu_op;
            o_branch_pc_sel <= i_uop.branch_pc_sel;
            o_rf_w_data_sel <= i_uop.rf_w_data_sel;
            o_csr_addr      <= i_uop.csr_addr;
            o_csr_w_type    <= i_uop.csr_w_type;
        end
    end
endmodule

//--- hdl/uop_decoder.sv
`timescale 1ns/1ps

module uop_decoder (
    inst_fields_if.consumer i_fields,
    uop_if.producer         o_uop
);
    import decode_pkg::*;

    logic f7_alt;
    logic f7_ok;

    assign f7_alt = (i_fields.funct7 == FUNCT7_ALT);
    assign f7_ok  = f7_alt || (i_fields.funct7 == FUNCT7_BASE);

    assign o_uop.valid       = i_fields.valid;
    assign o_uop.rf_w_addr   = i_fields.rd;
    assign o_uop.rf_r_addr_1 = i_fields.rs1;
    assign o_uop.rf_r_addr_2 = i_fields.rs2;
    assign o_uop.csr_addr    = i_fields.csr_addr;

    always_comb begin
        // unused selectors stay at the first enum value
        o_uop.illegal       = 1'b0;
        o_uop.rf_w_en       = 1'b0;
        o_uop.imm_type      = IMM_TYPE_I;
        o_uop.alu_arg_1_sel = ALU_ARG_1_SEL_REGFILE_R_DATA_1;
        o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_REGFILE_R_DATA_2;
        o_uop.alu_op        = ALU_OP_ADD;
        o_uop.data_mem_op   = DATA_MEM_OP_NONE;
        o_uop.branch_type   = BRANCH_TYPE_NONE;
        o_uop.branch_pc_sel = BRANCH_PC_SEL_PC_PLUS_IMM;
        o_uop.rf_w_data_sel = REGFILE_W_DATA_SEL_ALU;
        o_uop.csr_w_en      = 1'b0;
        o_uop.csr_w_type    = CSR_WRITE_TYPE_COPY;

        case (i_fields.opcode)
            OPCODE_LUI: begin
                o_uop.rf_w_en       = 1'b1;
                o_uop.imm_type      = IMM_TYPE_U;
                o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                o_uop.alu_op        = ALU_OP_ARG_2_BYPASS;
            end
            OPCODE_AUIPC: begin
                o_uop.rf_w_en       = 1'b1;
                o_uop.imm_type      = IMM_TYPE_U;
                o_uop.alu_arg_1_sel = ALU_ARG_1_SEL_PC;
                o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
            end
            // link value pc + 4 goes through the ALU
            OPCODE_JAL, OPCODE_JALR: begin
                o_uop.rf_w_en       = 1'b1;
                o_uop.alu_arg_1_sel = ALU_ARG_1_SEL_PC;
                o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_4;
                o_uop.branch_type   = BRANCH_TYPE_UNCONDITIONAL;
                if (i_fields.opcode == OPCODE_JAL) begin
                    o_uop.imm_type = IMM_TYPE_J;
                end else begin
                    o_uop.branch_pc_sel = BRANCH_PC_SEL_REGFILE_R_DATA_1_PLUS_IMM;
                end
            end
            OPCODE_BRANCH: begin
                o_uop.imm_type    = IMM_TYPE_B;
                o_uop.branch_type = BRANCH_TYPE_CONDITIONAL;
                case (i_fields.funct3)
                    FUNCT3_BEQ:  o_uop.alu_op = ALU_OP_SEQ;
                    FUNCT3_BNE:  o_uop.alu_op = ALU_OP_SNEQ;
                    FUNCT3_BLT:  o_uop.alu_op = ALU_OP_SLT;
                    FUNCT3_BGE:  o_uop.alu_op = ALU_OP_SGE;
                    FUNCT3_BLTU: o_uop.alu_op = ALU_OP_SLTU;
                    FUNCT3_BGEU: o_uop.alu_op = ALU_OP_SGEU;
                    default:     o_uop.illegal = 1'b1;
                endcase
            end
            OPCODE_LOAD: begin
                o_uop.rf_w_en       = 1'b1;
                o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                o_uop.rf_w_data_sel = REGFILE_W_DATA_SEL_DATA_MEM;
                case (i_fields.funct3)
                    FUNCT3_LB:  o_uop.data_mem_op = DATA_MEM_OP_LOAD_BYTE;
                    FUNCT3_LH:  o_uop.data_mem_op = DATA_MEM_OP_LOAD_HALF;
                    FUNCT3_LW:  o_uop.data_mem_op = DATA_MEM_OP_LOAD_WORD;
                    FUNCT3_LBU: o_uop.data_mem_op = DATA_MEM_OP_LOAD_BYTE_UNSIGNED;
                    FUNCT3_LHU: o_uop.data_mem_op = DATA_MEM_OP_LOAD_HALF_UNSIGNED;
                    default:    o_uop.illegal = 1'b1;
                endcase
            end
            OPCODE_STORE: begin
                o_uop.imm_type      = IMM_TYPE_S;
                o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                case (i_fields.funct3)
                    FUNCT3_SB: o_uop.data_mem_op = DATA_MEM_OP_STORE_BYTE;
                    FUNCT3_SH: o_uop.data_mem_op = DATA_MEM_OP_STORE_HALF;
                    FUNCT3_SW: o_uop.data_mem_op = DATA_MEM_OP_STORE_WORD;
                    default:   o_uop.illegal = 1'b1;
                endcase
            end
            OPCODE_ARITH_IMM, OPCODE_ARITH: begin
                o_uop.rf_w_en = 1'b1;
                if (i_fields.opcode == OPCODE_ARITH_IMM) begin
                    o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                end
                case (i_fields.funct3)
                    FUNCT3_SLL: begin
                        o_uop.alu_op  = ALU_OP_SLL;
                        o_uop.illegal = !f7_ok;
                    end
                    FUNCT3_SLT:  o_uop.alu_op = ALU_OP_SLT;
                    FUNCT3_SLTU: o_uop.alu_op = ALU_OP_SLTU;
                    FUNCT3_XOR:  o_uop.alu_op = ALU_OP_XOR;
                    FUNCT3_OR:   o_uop.alu_op = ALU_OP_OR;
                    FUNCT3_AND:  o_uop.alu_op = ALU_OP_AND;
                    FUNCT3_SRL_SRA: begin
                        o_uop.alu_op  = f7_alt ? ALU_OP_SRA : ALU_OP_SRL;
                        o_uop.illegal = !f7_ok;
                    end
                    // addi carries no funct7
                    FUNCT3_ADD_SUB: begin
                        if (i_fields.opcode == OPCODE_ARITH) begin
                            o_uop.alu_op  = f7_alt ? ALU_OP_SUB : ALU_OP_ADD;
                            o_uop.illegal = !f7_ok;
                        end
                    end
                endcase
            end
            OPCODE_SYSTEM: begin
                o_uop.rf_w_data_sel = REGFILE_W_DATA_SEL_CSR;
                o_uop.rf_w_en       = 1'b1;
                o_uop.csr_w_en      = 1'b1;
                case (i_fields.funct3)
                    FUNCT3_CSRRW:  o_uop.csr_w_type = CSR_WRITE_TYPE_COPY;
                    FUNCT3_CSRRS:  o_uop.csr_w_type = CSR_WRITE_TYPE_SET;
                    FUNCT3_CSRRC:  o_uop.csr_w_type = CSR_WRITE_TYPE_CLEAR;
                    FUNCT3_CSRRWI: o_uop.csr_w_type = CSR_WRITE_TYPE_COPY;
                    FUNCT3_CSRRSI: o_uop.csr_w_type = CSR_WRITE_TYPE_SET;
                    FUNCT3_CSRRCI: o_uop.csr_w_type = CSR_WRITE_TYPE_CLEAR;
                    // ecall, mret, wfi and friends
                    default:       o_uop.illegal = 1'b1;
                endcase
                // funct3[2] picks the zimm forms
                if (i_fields.funct3[2]) begin
                    o_uop.imm_type      = IMM_TYPE_CSR;
                    o_uop.alu_arg_2_sel = ALU_ARG_2_SEL_IMM;
                    o_uop.alu_op        = ALU_OP_ARG_2_BYPASS;
                end else begin
                    o_uop.alu_op = ALU_OP_ARG_1_BYPASS;
                end
            end
            // fence and undefined opcodes
            default: o_uop.illegal = 1'b1;
        endcase
    end
endmodule

//--- hdl/inst_capture.sv
`timescale 1ns/1ps

module inst_capture (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  decode_pkg::inst_t i_inst,
    inst_fields_if.producer   o_fields
);
    import decode_pkg::*;

    logic  valid_q;
    inst_t inst_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    // word held until the next valid
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            inst_q <= i_inst;
        end
    end

    assign o_fields.valid    = valid_q;
    assign o_fields.opcode   = inst_q[6:0];
    assign o_fields.rd       = inst_q[11:7];
    assign o_fields.funct3   = inst_q[14:12];
    assign o_fields.rs1      = inst_q[19:15];
    assign o_fields.rs2      = inst_q[24:20];
    assign o_fields.funct7   = inst_q[31:25];
    assign o_fields.csr_addr = inst_q[31:20];
endmodule

//--- hdl/uop_if.sv
`timescale 1ns/1ps

interface uop_if;
    import decode_pkg::*;

    logic                valid;
    logic                illegal;
    logic                rf_w_en;
    reg_addr_t           rf_w_addr;
    reg_addr_t           rf_r_addr_1;
    reg_addr_t           rf_r_addr_2;
    imm_type_e           imm_type;
    alu_arg_1_sel_e      alu_arg_1_sel;
    alu_arg_2_sel_e      alu_arg_2_sel;
    alu_op_e             alu_op;
    data_mem_op_e        data_mem_op;
    branch_type_e        branch_type;
    branch_pc_sel_e      branch_pc_sel;
    regfile_w_data_sel_e rf_w_data_sel;
    csr_addr_t           csr_addr;
    logic                csr_w_en;
    csr_write_type_e     csr_w_type;

    modport producer (
        output valid, illegal, rf_w_en, rf_w_addr, rf_r_addr_1, rf_r_addr_2, imm_type,
               alu_arg_1_sel, alu_arg_2_sel, alu_op, data_mem_op, branch_type,
               branch_pc_sel, rf_w_data_sel, csr_addr, csr_w_en, csr_w_type
    );
    modport consumer (
        input valid, illegal, rf_w_en, rf_w_addr, rf_r_addr_1, rf_r_addr_2, imm_type,
              alu_arg_1_sel, alu_arg_2_sel, alu_op, data_mem_op, branch_type,
              branch_pc_sel, rf_w_data_sel, csr_addr, csr_w_en, csr_w_type
    );
endinterface

//--- hdl/inst_fields_if.sv
`timescale 1ns/1ps

interface inst_fields_if;
    import decode_pkg::*;

    logic      valid;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    csr_addr_t csr_addr;

    modport producer (output valid, opcode, funct3, funct7, rd, rs1, rs2, csr_addr);
    modport consumer (input valid, opcode, funct3, funct7, rd, rs1, rs2, csr_addr);
endinterface

//--- hdl/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    localparam opcode_t OPCODE_LUI       = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC     = 7'b0010111;
    localparam opcode_t OPCODE_JAL       = 7'b1101111;
    localparam opcode_t OPCODE_JALR      = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH    = 7'b1100011;
    localparam opcode_t OPCODE_LOAD      = 7'b0000011;
    localparam opcode_t OPCODE_STORE     = 7'b0100011;
    localparam opcode_t OPCODE_ARITH_IMM = 7'b0010011;
    localparam opcode_t OPCODE_ARITH     = 7'b0110011;
    localparam opcode_t OPCODE_SYSTEM    = 7'b1110011;

    localparam funct7_t FUNCT7_BASE = 7'h00;
    // selects SUB, SRA and SRAI
    localparam funct7_t FUNCT7_ALT  = 7'h20;

    // conditional branches
    localparam funct3_t FUNCT3_BEQ  = 3'd0;
    localparam funct3_t FUNCT3_BNE  = 3'd1;
    localparam funct3_t FUNCT3_BLT  = 3'd4;
    localparam funct3_t FUNCT3_BGE  = 3'd5;
    localparam funct3_t FUNCT3_BLTU = 3'd6;
    localparam funct3_t FUNCT3_BGEU = 3'd7;

    // loads and stores
    localparam funct3_t FUNCT3_LB  = 3'd0;
    localparam funct3_t FUNCT3_LH  = 3'd1;
    localparam funct3_t FUNCT3_LW  = 3'd2;
    localparam funct3_t FUNCT3_LBU = 3'd4;
    localparam funct3_t FUNCT3_LHU = 3'd5;
    localparam funct3_t FUNCT3_SB  = 3'd0;
    localparam funct3_t FUNCT3_SH  = 3'd1;
    localparam funct3_t FUNCT3_SW  = 3'd2;

    // shared by register and immediate arithmetic
    localparam funct3_t FUNCT3_ADD_SUB = 3'd0;
    localparam funct3_t FUNCT3_SLL     = 3'd1;
    localparam funct3_t FUNCT3_SLT     = 3'd2;
    localparam funct3_t FUNCT3_SLTU    = 3'd3;
    localparam funct3_t FUNCT3_XOR     = 3'd4;
    localparam funct3_t FUNCT3_SRL_SRA = 3'd5;
    localparam funct3_t FUNCT3_OR      = 3'd6;
    localparam funct3_t FUNCT3_AND     = 3'd7;

    localparam funct3_t FUNCT3_CSRRW  = 3'd1;
    localparam funct3_t FUNCT3_CSRRS  = 3'd2;
    localparam funct3_t FUNCT3_CSRRC  = 3'd3;
    localparam funct3_t FUNCT3_CSRRWI = 3'd5;
    localparam funct3_t FUNCT3_CSRRSI = 3'd6;
    localparam funct3_t FUNCT3_CSRRCI = 3'd7;

    typedef enum logic [2:0] {
        IMM_TYPE_I, IMM_TYPE_S, IMM_TYPE_B, IMM_TYPE_U, IMM_TYPE_J, IMM_TYPE_CSR
    } imm_type_e;

    typedef enum logic {
        ALU_ARG_1_SEL_REGFILE_R_DATA_1, ALU_ARG_1_SEL_PC
    } alu_arg_1_sel_e;

    typedef enum logic [1:0] {
        ALU_ARG_2_SEL_REGFILE_R_DATA_2, ALU_ARG_2_SEL_IMM, ALU_ARG_2_SEL_4
    } alu_arg_2_sel_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU, ALU_OP_XOR,
        ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND, ALU_OP_SEQ, ALU_OP_SNEQ,
        ALU_OP_SGE, ALU_OP_SGEU, ALU_OP_ARG_1_BYPASS, ALU_OP_ARG_2_BYPASS
    } alu_op_e;

    typedef enum logic [3:0] {
        DATA_MEM_OP_NONE, DATA_MEM_OP_LOAD_BYTE, DATA_MEM_OP_LOAD_HALF,
        DATA_MEM_OP_LOAD_WORD, DATA_MEM_OP_LOAD_BYTE_UNSIGNED,
        DATA_MEM_OP_LOAD_HALF_UNSIGNED, DATA_MEM_OP_STORE_BYTE,
        DATA_MEM_OP_STORE_HALF, DATA_MEM_OP_STORE_WORD
    } data_mem_op_e;

    typedef enum logic [1:0] {
        BRANCH_TYPE_NONE, BRANCH_TYPE_CONDITIONAL, BRANCH_TYPE_UNCONDITIONAL
    } branch_type_e;

    typedef enum logic {
        BRANCH_PC_SEL_PC_PLUS_IMM, BRANCH_PC_SEL_REGFILE_R_DATA_1_PLUS_IMM
    } branch_pc_sel_e;

    typedef enum logic [1:0] {
        REGFILE_W_DATA_SEL_ALU, REGFILE_W_DATA_SEL_DATA_MEM, REGFILE_W_DATA_SEL_CSR
    } regfile_w_data_sel_e;

    typedef enum logic [1:0] {
        CSR_WRITE_TYPE_COPY, CSR_WRITE_TYPE_SET, CSR_WRITE_TYPE_CLEAR
    } csr_write_type_e;

endpackage
